//--- Makefile
TOP := if_stage_tb

.PHONY: run build lint clean

run: build
	./obj_dir/sim | tee sim.log
	grep -q "sim passed" sim.log

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f -o sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir sim.log

//--- list.f
rtl/fetch_pkg.sv
rtl/pc_gen.sv
rtl/icache.sv
rtl/axi_rd_master.sv
rtl/axi_rom_slave.sv
rtl/if_stage.sv
testbench/tb_clk_gen.sv
testbench/if_stage_props.sv
testbench/if_stage_tb.sv

//--- rom.hex
// one 32-bit instruction word per line, word addresses 0 to 31
00100093
00200113
00300193
00400213
00500293
00600313
00700393
00800413
00900493
00a00513
00b00593
00c00613
00d00693
00e00713
00f00793
01000813
01100893
01200913
01300993
01400a13
01500a93
01600b13
01700b93
01800c13
01900c93
01a00d13
01b00d93
01c00e13
01d00e93
01e00f13
01f00f93
02000093

//--- rtl/axi_rd_master.sv
`timescale 1ns/100ps

module axi_rd_master (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         refill_req_i,
  input  logic [fetch_pkg::ADDR_W-1:0] refill_addr_i,
  output logic                         beat_valid_o,
  output logic [fetch_pkg::INST_W-1:0] beat_data_o,
  output logic                         refill_done_o,
  output logic                         ar_valid_o,
  input  logic                         ar_ready_i,
  output fetch_pkg::axi_ar_t           ar_o,
  input  logic                         r_valid_i,
  output logic                         r_ready_o,
  input  fetch_pkg::axi_r_t            r_i
);

  fetch_pkg::rdm_state_e        state_q;
  logic [fetch_pkg::ADDR_W-1:0] addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= fetch_pkg::M_IDLE;
    end else begin
      case (state_q)
        fetch_pkg::M_IDLE: if (refill_req_i) state_q <= fetch_pkg::M_ADDR;
        fetch_pkg::M_ADDR: if (ar_ready_i) state_q <= fetch_pkg::M_DATA;
        fetch_pkg::M_DATA: if (r_valid_i && r_i.last) state_q <= fetch_pkg::M_IDLE;
        default:           state_q <= fetch_pkg::M_IDLE;
      endcase
    end
  end

  // line address captured when the burst starts
  always_ff @(posedge clk) begin
    if (state_q == fetch_pkg::M_IDLE && refill_req_i) begin
      addr_q <= refill_addr_i;
    end
  end

  assign ar_valid_o = (state_q == fetch_pkg::M_ADDR);
  assign ar_o.addr  = addr_q;
  assign ar_o.len   = 8'(fetch_pkg::LINE_WORDS - 1);
  assign ar_o.burst = fetch_pkg::BURST_INCR;

  assign r_ready_o = (state_q == fetch_pkg::M_DATA);

  // resp is not checked, an error beat still fills the line
  assign beat_valid_o  = r_ready_o && r_valid_i;
  assign beat_data_o   = r_i.data;
  assign refill_done_o = beat_valid_o && r_i.last;

endmodule

//--- rtl/axi_rom_slave.sv
`timescale 1ns/100ps

module axi_rom_slave (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ar_valid_i,
  output logic               ar_ready_o,
  input  fetch_pkg::axi_ar_t ar_i,
  output logic               r_valid_o,
  input  logic               r_ready_i,
  output fetch_pkg::axi_r_t  r_o
);

  logic [fetch_pkg::INST_W-1:0] mem [fetch_pkg::ROM_WORDS];

  logic                            ar_ready_q;
  logic                            r_valid_q;
  logic [7:0]                      beat_q;
  logic [7:0]                      len_q;
  logic [fetch_pkg::ROM_IDX_W-1:0] idx_q;  // wraps at the rom size
  logic                            incr_q;
  logic                            ar_fire;
  logic                            r_fire;

  initial begin
    $readmemh("rom.hex", mem);
  end

  assign ar_fire = ar_valid_i && ar_ready_q;
  assign r_fire  = r_valid_q && r_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ar_ready_q <= 1'b0;
      r_valid_q  <= 1'b0;
      beat_q     <= '0;
    end else begin
      if (ar_fire) begin
        ar_ready_q <= 1'b0;
        r_valid_q  <= 1'b1;  // first beat right after the address
        beat_q     <= '0;
      end else if (ar_valid_i && !ar_ready_q && !r_valid_q) begin
        ar_ready_q <= 1'b1;
      end
      if (r_fire) begin
        if (r_o.last) begin
          r_valid_q <= 1'b0;
        end else begin
          beat_q <= beat_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      idx_q  <= ar_i.addr[fetch_pkg::BYTE_OFF_W +: fetch_pkg::ROM_IDX_W];
      len_q  <= ar_i.len;
      incr_q <= (ar_i.burst != fetch_pkg::BURST_FIXED);
    end else if (r_fire && incr_q) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  assign ar_ready_o = ar_ready_q;
  assign r_valid_o  = r_valid_q;
  assign r_o.data   = mem[idx_q];
  assign r_o.resp   = fetch_pkg::RESP_OKAY;
  assign r_o.last   = (beat_q == len_q);

endmodule

//--- rtl/fetch_pkg.sv
package fetch_pkg;

  localparam int ADDR_W     = 32;
  localparam int INST_W     = 32;
  localparam int LINE_WORDS = 4;
  localparam int NUM_LINES  = 4;
  localparam int ROM_WORDS  = 32;

  localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_0000;
  localparam logic [INST_W-1:0] NOP_INST = 32'h0000_0013;  // addi x0, x0, 0

  // address slicing for the cache and the rom
  localparam int BYTE_OFF_W = 2;
  localparam int WORD_OFF_W = $clog2(LINE_WORDS);
  localparam int LINE_IDX_W = $clog2(NUM_LINES);
  localparam int LINE_LSB   = BYTE_OFF_W + WORD_OFF_W;
  localparam int TAG_W      = ADDR_W - LINE_LSB - LINE_IDX_W;
  localparam int ROM_IDX_W  = $clog2(ROM_WORDS);

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic {
    C_RUN    = 1'b0,
    C_REFILL = 1'b1
  } cache_state_e;

  typedef enum logic [1:0] {
    M_IDLE = 2'b00,
    M_ADDR = 2'b01,
    M_DATA = 2'b10
  } rdm_state_e;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;    // beats minus one
    axi_burst_e        burst;
  } axi_ar_t;

  typedef struct packed {
    logic [INST_W-1:0] data;
    axi_resp_e         resp;
    logic              last;
  } axi_r_t;

  typedef struct packed {
    logic [ADDR_W-1:0] pc;
    logic [INST_W-1:0] inst;
  } fetch_rsp_t;

endpackage

//--- rtl/icache.sv
`timescale 1ns/100ps

module icache (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         req_valid_i,
  input  logic [fetch_pkg::ADDR_W-1:0] pc_i,
  output logic                         req_ready_o,
  input  logic                         redirect_valid_i,
  output fetch_pkg::fetch_rsp_t        rsp_o,
  output logic                         rsp_valid_o,
  input  logic                         rsp_ready_i,
  output logic                         refill_req_o,
  output logic [fetch_pkg::ADDR_W-1:0] refill_addr_o,
  input  logic                         beat_valid_i,
  input  logic [fetch_pkg::INST_W-1:0] beat_data_i,
  input  logic                         refill_done_i
);

  fetch_pkg::cache_state_e state_q;

  logic [fetch_pkg::NUM_LINES-1:0] line_vld_q;
  logic [fetch_pkg::TAG_W-1:0]     tag_q  [fetch_pkg::NUM_LINES];
  logic [fetch_pkg::INST_W-1:0]    data_q [fetch_pkg::NUM_LINES][fetch_pkg::LINE_WORDS];

  logic [fetch_pkg::ADDR_W-1:0]     miss_pc_q;
  logic [fetch_pkg::WORD_OFF_W-1:0] beat_cnt_q;
  logic                             refill_q;
  logic                             discard_q;  // redirect seen during refill
  fetch_pkg::fetch_rsp_t            rsp_q;
  logic                             rsp_valid_q;

  logic [fetch_pkg::LINE_IDX_W-1:0] req_idx;
  logic [fetch_pkg::WORD_OFF_W-1:0] req_off;
  logic [fetch_pkg::TAG_W-1:0]      req_tag;
  logic                             hit;
  logic                             req_fire;
  logic [fetch_pkg::LINE_IDX_W-1:0] miss_idx;
  logic [fetch_pkg::WORD_OFF_W-1:0] miss_off;
  logic [fetch_pkg::INST_W-1:0]     fill_word;
  logic                             serve_fill;

  assign req_off = pc_i[fetch_pkg::BYTE_OFF_W +: fetch_pkg::WORD_OFF_W];
  assign req_idx = pc_i[fetch_pkg::LINE_LSB +: fetch_pkg::LINE_IDX_W];
  assign req_tag = pc_i[fetch_pkg::ADDR_W-1 -: fetch_pkg::TAG_W];

  assign miss_off = miss_pc_q[fetch_pkg::BYTE_OFF_W +: fetch_pkg::WORD_OFF_W];
  assign miss_idx = miss_pc_q[fetch_pkg::LINE_LSB +: fetch_pkg::LINE_IDX_W];

  assign hit = line_vld_q[req_idx] && (tag_q[req_idx] == req_tag);

  // stall while refilling or while decode holds the output
  assign req_ready_o = (state_q == fetch_pkg::C_RUN) && (!rsp_valid_q || rsp_ready_i);
  assign req_fire    = req_valid_i && req_ready_o;

  // on the last beat the wanted word may still be on the bus
  assign fill_word  = (beat_cnt_q == miss_off) ? beat_data_i : data_q[miss_idx][miss_off];
  assign serve_fill = refill_done_i && !discard_q && !redirect_valid_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= fetch_pkg::C_RUN;
      line_vld_q  <= '0;
      beat_cnt_q  <= '0;
      refill_q    <= 1'b0;
      discard_q   <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      case (state_q)
        fetch_pkg::C_RUN: begin
          if (req_fire && !hit) begin
            state_q             <= fetch_pkg::C_REFILL;
            line_vld_q[req_idx] <= 1'b0;  // line is about to be overwritten
            beat_cnt_q          <= '0;
            refill_q            <= 1'b1;
            discard_q           <= 1'b0;
          end
        end
        fetch_pkg::C_REFILL: begin
          if (beat_valid_i) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
          end
          if (redirect_valid_i) begin
            discard_q <= 1'b1;
          end
          if (refill_done_i) begin
            state_q              <= fetch_pkg::C_RUN;
            line_vld_q[miss_idx] <= 1'b1;  // filled even if discarded
            refill_q             <= 1'b0;
          end
        end
        default: state_q <= fetch_pkg::C_RUN;
      endcase

      if (redirect_valid_i) begin
        rsp_valid_q <= 1'b0;
      end else if (req_fire) begin
        rsp_valid_q <= hit;
      end else if (serve_fill) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  // arrays and payload
  always_ff @(posedge clk) begin
    if (req_fire && !hit) begin
      miss_pc_q <= pc_i;
    end
    if (beat_valid_i) begin
      data_q[miss_idx][beat_cnt_q] <= beat_data_i;
    end
    if (refill_done_i) begin
      tag_q[miss_idx] <= miss_pc_q[fetch_pkg::ADDR_W-1 -: fetch_pkg::TAG_W];
    end

    if (redirect_valid_i) begin
      rsp_q.inst <= fetch_pkg::NOP_INST;
    end else if (req_fire && hit) begin
      rsp_q <= '{pc: pc_i, inst: data_q[req_idx][req_off]};
    end else if (serve_fill) begin
      rsp_q <= '{pc: miss_pc_q, inst: fill_word};
    end
  end

  assign rsp_o         = rsp_q;
  assign rsp_valid_o   = rsp_valid_q;
  assign refill_req_o  = refill_q;
  assign refill_addr_o = {miss_pc_q[fetch_pkg::ADDR_W-1:fetch_pkg::LINE_LSB],
                          {fetch_pkg::LINE_LSB{1'b0}}};

endmodule

//--- rtl/if_stage.sv
`timescale 1ns/100ps

module if_stage (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         redirect_valid_i,
  input  logic [fetch_pkg::ADDR_W-1:0] redirect_pc_i,
  input  logic                         inst_ready_i,
  output logic                         inst_valid_o,
  output fetch_pkg::fetch_rsp_t        inst_o
);

  logic                         req_valid;
  logic                         req_ready;
  logic [fetch_pkg::ADDR_W-1:0] pc;
  logic                         refill_req;
  logic [fetch_pkg::ADDR_W-1:0] refill_addr;
  logic                         beat_valid;
  logic [fetch_pkg::INST_W-1:0] beat_data;
  logic                         refill_done;
  logic                         ar_valid;
  logic                         ar_ready;
  fetch_pkg::axi_ar_t           ar_pld;
  logic                         r_valid;
  logic                         r_ready;
  fetch_pkg::axi_r_t            r_pld;

  pc_gen u_pc_gen (
    .clk              (clk),
    .rst_n            (rst_n),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .req_ready_i      (req_ready),
    .req_valid_o      (req_valid),
    .pc_o             (pc)
  );

  icache u_icache (
    .clk              (clk),
    .rst_n            (rst_n),
    .req_valid_i      (req_valid),
    .pc_i             (pc),
    .req_ready_o      (req_ready),
    .redirect_valid_i (redirect_valid_i),
    .rsp_o            (inst_o),
    .rsp_valid_o      (inst_valid_o),
    .rsp_ready_i      (inst_ready_i),
    .refill_req_o     (refill_req),
    .refill_addr_o    (refill_addr),
    .beat_valid_i     (beat_valid),
    .beat_data_i      (beat_data),
    .refill_done_i    (refill_done)
  );

  axi_rd_master u_axi_rd_master (
    .clk           (clk),
    .rst_n         (rst_n),
    .refill_req_i  (refill_req),
    .refill_addr_i (refill_addr),
    .beat_valid_o  (beat_valid),
    .beat_data_o   (beat_data),
    .refill_done_o (refill_done),
    .ar_valid_o    (ar_valid),
    .ar_ready_i    (ar_ready),
    .ar_o          (ar_pld),
    .r_valid_i     (r_valid),
    .r_ready_o     (r_ready),
    .r_i           (r_pld)
  );

  axi_rom_slave u_axi_rom_slave (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .ar_i       (ar_pld),
    .r_valid_o  (r_valid),
    .r_ready_i  (r_ready),
    .r_o        (r_pld)
  );

endmodule

//--- rtl/pc_gen.sv
`timescale 1ns/100ps

module pc_gen (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         redirect_valid_i,
  input  logic [fetch_pkg::ADDR_W-1:0] redirect_pc_i,
  input  logic                         req_ready_i,
  output logic                         req_valid_o,
  output logic [fetch_pkg::ADDR_W-1:0] pc_o
);

  logic [fetch_pkg::ADDR_W-1:0] pc_q;
  logic [fetch_pkg::ADDR_W-1:0] pc_next;
  logic                         req_fire;

  // no request while the pc is being replaced
  assign req_valid_o = !redirect_valid_i;
  assign req_fire    = req_valid_o && req_ready_i;

  always_comb begin
    pc_next = pc_q;
    if (redirect_valid_i) begin
      pc_next = redirect_pc_i;
    end else if (req_fire) begin
      pc_next = pc_q + 32'd4;  // sequential step
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= fetch_pkg::RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

endmodule

//--- testbench/if_stage_props.sv
`timescale 1ns/100ps

module if_stage_props (
  input logic                         clk,
  input logic                         rst_n,
  input logic                         redirect_valid_i,
  input logic [fetch_pkg::ADDR_W-1:0] redirect_pc_i,
  input logic                         inst_ready_i,
  input logic                         inst_valid_i,
  input fetch_pkg::fetch_rsp_t        inst_i,
  input logic                         ar_valid_i,
  input logic                         ar_ready_i,
  input fetch_pkg::axi_ar_t           ar_i,
  input logic                         r_valid_i,
  input logic                         r_ready_i,
  input fetch_pkg::axi_r_t            r_i
);

  logic [fetch_pkg::INST_W-1:0] rom_ref [fetch_pkg::ROM_WORDS];
  logic [fetch_pkg::ADDR_W-1:0] exp_pc_q;  // pc of the next instruction decode should see
  logic [7:0]                   r_cnt_q;
  logic                         take;
  logic [fetch_pkg::INST_W-1:0] exp_inst;

  initial begin
    $readmemh("rom.hex", rom_ref);
  end

  assign take     = inst_valid_i && inst_ready_i;
  assign exp_inst = rom_ref[(inst_i.pc >> 2) % fetch_pkg::ROM_WORDS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_pc_q <= fetch_pkg::RESET_PC;
      r_cnt_q  <= '0;
    end else begin
      if (redirect_valid_i) begin
        exp_pc_q <= redirect_pc_i;
      end else if (take) begin
        exp_pc_q <= inst_i.pc + 32'd4;
      end
      if (ar_valid_i && ar_ready_i) begin
        r_cnt_q <= '0;  // new burst
      end else if (r_valid_i && r_ready_i) begin
        r_cnt_q <= r_cnt_q + 1'b1;
      end
    end
  end

  a_inst_data: assert property (@(posedge clk) disable iff (!rst_n)
    take |-> inst_i.inst == exp_inst)
    else $error("ERROR %0t inst_o.inst got %h expected %h",
                $time, $sampled(inst_i.inst), $sampled(exp_inst));

  // sequential order and redirect target
  a_inst_pc: assert property (@(posedge clk) disable iff (!rst_n)
    take |-> inst_i.pc == exp_pc_q)
    else $error("ERROR %0t inst_o.pc got %h expected %h",
                $time, $sampled(inst_i.pc), $sampled(exp_pc_q));

  a_inst_hold: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid_i && !inst_ready_i && !redirect_valid_i |=> inst_valid_i && $stable(inst_i))
    else $error("instruction output dropped or changed while decode was stalling");

  a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
    else $error("ar_valid dropped or the AR payload changed before ar_ready");

  a_ar_burst: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid_i |-> ar_i.burst == fetch_pkg::BURST_INCR)
    else $error("ERROR %0t ar_o.burst got %0d expected %0d",
                $time, $sampled(ar_i.burst), fetch_pkg::BURST_INCR);

  a_ar_len: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid_i |-> ar_i.len == fetch_pkg::LINE_WORDS - 1)
    else $error("ERROR %0t ar_o.len got %0d expected %0d",
                $time, $sampled(ar_i.len), fetch_pkg::LINE_WORDS - 1);

  a_r_last: assert property (@(posedge clk) disable iff (!rst_n)
    r_valid_i && r_ready_i |-> r_i.last == (r_cnt_q == fetch_pkg::LINE_WORDS - 1))
    else $error("ERROR %0t r_o.last got %b expected %b",
                $time, $sampled(r_i.last), $sampled(r_cnt_q == fetch_pkg::LINE_WORDS - 1));

  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
    else $error("r_valid dropped or the R payload changed before r_ready");

  a_reset: assert property (@(posedge clk)
    !rst_n |-> !inst_valid_i && !ar_valid_i)
    else $error("inst_valid_o or ar_valid high while reset is asserted");

endmodule

bind if_stage if_stage_props u_props (
  .clk              (clk),
  .rst_n            (rst_n),
  .redirect_valid_i (redirect_valid_i),
  .redirect_pc_i    (redirect_pc_i),
  .inst_ready_i     (inst_ready_i),
  .inst_valid_i     (inst_valid_o),
  .inst_i           (inst_o),
  .ar_valid_i       (ar_valid),
  .ar_ready_i       (ar_ready),
  .ar_i             (ar_pld),
  .r_valid_i        (r_valid),
  .r_ready_i        (r_ready),
  .r_i              (r_pld)
);

//--- testbench/if_stage_tb.sv
`timescale 1ns/100ps

module if_stage_tb;

  localparam int NUM_INST     = 200;
  localparam int WAIT_LIMIT   = 200;  // cycles allowed per accepted instruction
  localparam int RESET_CYCLES = 5;

  logic                         clk;
  logic                         rst_n;
  logic                         redirect_valid;
  logic [fetch_pkg::ADDR_W-1:0] redirect_pc;
  logic                         inst_ready;
  logic                         inst_valid;
  fetch_pkg::fetch_rsp_t        inst;

  logic [31:0] lfsr_q;
  logic        stim_on;
  logic        run_ok;
  logic        fail_shown;
  int          accepted;
  int          redirects;

  tb_clk_gen u_clk_gen (
    .clk_o (clk)
  );

  if_stage dut_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .inst_ready_i     (inst_ready),
    .inst_valid_o     (inst_valid),
    .inst_o           (inst)
  );

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [7:0] bits);
    int i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      bits   = {bits[6:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic drive_inputs();
    logic [7:0] r;
    take_bits(4, r);
    inst_ready <= (r < 8'd11);  // 11 of 16, about 70 %
    take_bits(4, r);
    if (!redirect_valid && r == 8'd0) begin
      take_bits(5, r);
      redirect_valid <= 1'b1;
      redirect_pc    <= {25'd0, r[4:0], 2'b00};  // any word of the rom
      redirects++;
    end else begin
      redirect_valid <= 1'b0;
    end
  endtask

  always @(posedge clk) begin
    if (stim_on) begin
      drive_inputs();
    end
  end

  // inputs are stable mid-cycle, so count handshakes here
  always @(negedge clk) begin
    if (rst_n && inst_valid && inst_ready) begin
      accepted++;
    end
  end

  initial begin
    int seen;
    int waited;
    lfsr_q         = 32'h77d2;
    rst_n          = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    inst_ready     = 1'b0;
    stim_on        = 1'b0;
    run_ok         = 1'b0;
    fail_shown     = 1'b0;
    accepted       = 0;
    redirects      = 0;

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n   <= 1'b1;
    stim_on <= 1'b1;

    seen = 0;
    while (seen < NUM_INST) begin
      waited = 0;
      while (accepted == seen && waited < WAIT_LIMIT) begin
        @(posedge clk);
        waited++;
      end
      if (accepted == seen) begin
        fail_shown = 1'b1;
        $display("no instruction accepted within %0d cycles after %0d instructions",
                 WAIT_LIMIT, seen);
        $display("sim failed");
        $fatal(1, "fetch stalled");
      end
      seen = accepted;
    end

    stim_on <= 1'b0;
    repeat (4) @(posedge clk);  // let the last checks fire
    $display("accepted %0d instructions with %0d redirects", accepted, redirects);
    run_ok = 1'b1;
    $display("sim passed");
    $finish;
  end

  final begin
    if (!run_ok && !fail_shown) begin
      $display("sim failed");
    end
  end

endmodule

//--- testbench/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o
);

  // 40 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #20 clk_o = ~clk_o;
    end
  end

endmodule
